// File: logic_cmp.f
+incdir+sim
verilog/logic_cmp_pkg.sv
verilog/issue_buffer.sv
verilog/issue_select.sv
verilog/logic_cmp_exec.sv
verilog/reg_file.sv
verilog/logic_cmp.sv
sim/logic_cmp_tb.sv

// File: sim/ref_model.svh
/*
 * Reference model of register values, pending bits and instructions in flight,
 * the expected result rule and the LCG random source
 */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

int unsigned lcg_state = 32'd27775;
logic [63:0] m_val [32];
bit m_pend [32];
bit fl_valid [32];	// At most one instruction in flight per destination
logic_cmp_pkg::lc_op_e fl_op [32];
int fl_rs1 [32];
int fl_rs2 [32];
logic [63:0] fl_imm [32];
int fl_time [32];	// Edge at which the dispatch was accepted

// Upper half of the state, the low bits of an LCG repeat too quickly
function automatic logic [15:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state[31:16];
endfunction

function automatic logic [63:0] rand_word();
	return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
endfunction

function automatic logic [63:0] rand_imm();
	logic [15:0] w;
	w = lcg_next();
	return {{52{w[11]}}, w[11:0]};	// Sign-extended 12-bit immediate
endfunction

function automatic bit uses_imm(logic_cmp_pkg::lc_op_e op);
	case (op)
		logic_cmp_pkg::OP_SLTI, logic_cmp_pkg::OP_SLTIU, logic_cmp_pkg::OP_XORI,
		logic_cmp_pkg::OP_ORI, logic_cmp_pkg::OP_ANDI: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [63:0] expect_value(logic_cmp_pkg::lc_op_e op, logic [63:0] a,
		logic [63:0] b, logic [63:0] imm);
	logic [63:0] src2;
	src2 = uses_imm(op) ? imm : b;
	case (op)
		logic_cmp_pkg::OP_SLTI, logic_cmp_pkg::OP_SLT: return {63'd0, $signed(a) < $signed(src2)};
		logic_cmp_pkg::OP_SLTIU, logic_cmp_pkg::OP_SLTU: return {63'd0, a < src2};
		logic_cmp_pkg::OP_XORI, logic_cmp_pkg::OP_XOR: return a ^ src2;
		logic_cmp_pkg::OP_ORI, logic_cmp_pkg::OP_OR: return a | src2;
		default: return a & src2;
	endcase
endfunction

// A register may take a new writer only when nothing in flight still reads it
function automatic bit reg_free(int r);
	if (m_pend[r])
		return 1'b0;
	for (int k = 0; k < 32; k++) begin
		if (fl_valid[k] && (fl_rs1[k] == r || (!uses_imm(fl_op[k]) && fl_rs2[k] == r)))
			return 1'b0;
	end
	return 1'b1;
endfunction

function automatic int pick_free_reg(int start);
	for (int k = 0; k < 32; k++) begin
		if (reg_free((start + k) % 32))
			return (start + k) % 32;
	end
	return -1;
endfunction

function automatic bit all_idle();
	for (int k = 0; k < 32; k++) begin
		if (fl_valid[k])
			return 1'b0;
	end
	return 1'b1;
endfunction

`endif

// File: sim/logic_cmp_tb.sv
/*
 * Testbench for the logic and compare issue path: clock, reset,
 * directed and random tests checked by assertions, timeout and report
 */
`timescale 1ns/1ns
`default_nettype none

module logic_cmp_tb;

	localparam int TIMEOUT_CYCLES = 2000;

	logic CLK;
	logic rst_n;
	logic dispatch_valid;
	logic_cmp_pkg::lc_op_e dispatch_op;
	logic [4:0] dispatch_rd;
	logic [4:0] dispatch_rs1;
	logic [4:0] dispatch_rs2;
	logic [63:0] dispatch_imm;
	logic credit_return;
	logic alloc_valid;
	logic [4:0] alloc_rd;
	logic ext_wb_valid;
	logic [4:0] ext_wb_rd;
	logic [63:0] ext_wb_data;
	logic result_valid;
	logic [4:0] result_rd;
	logic [63:0] result_data;

	int cycles = 0;
	int errors = 0;
	int results = 0;
	int dispatched = 0;
	int credits = logic_cmp_pkg::BUF_DEPTH;
	int credit_seen = 0;
	bit check_latency = 1'b0;
	int ext_q [$];	// Allocated registers still waiting for their external writeback

	`include "ref_model.svh"

	logic_cmp uut (
		.CLK(CLK), .rst_n(rst_n),
		.dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
		.dispatch_rd(dispatch_rd), .dispatch_rs1(dispatch_rs1),
		.dispatch_rs2(dispatch_rs2), .dispatch_imm(dispatch_imm),
		.credit_return(credit_return),
		.alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
		.ext_wb_valid(ext_wb_valid), .ext_wb_rd(ext_wb_rd), .ext_wb_data(ext_wb_data),
		.result_valid(result_valid), .result_rd(result_rd), .result_data(result_data)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) cycles++;

	initial begin
		while (cycles < TIMEOUT_CYCLES)
			@(posedge CLK);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// Results leave execute exactly one cycle after their credit returns
	a_result_follows_credit: assert property (@(posedge CLK) disable iff (!rst_n)
		credit_return |=> result_valid) else begin
		$display("result_valid did not follow credit_return by one cycle");
		errors++;
	end
	a_no_stray_result: assert property (@(posedge CLK) disable iff (!rst_n)
		!credit_return |=> !result_valid) else begin
		$display("result_valid rose without an issue one cycle before");
		errors++;
	end

	task automatic check_result();
		logic [63:0] exp;
		int r;
		r = result_rd;
		a_in_flight: assert (fl_valid[r]) else begin
			$display("result arrived for register %0d with no instruction in flight", r);
			errors++;
		end
		if (fl_valid[r]) begin
			exp = expect_value(fl_op[r], m_val[fl_rs1[r]], m_val[fl_rs2[r]], fl_imm[r]);
			a_data: assert (result_data === exp) else begin
				$display("mismatch result_data rd %0d: got %h expected %h", r, result_data, exp);
				errors++;
			end
			if (check_latency) begin
				a_latency: assert (cycles - fl_time[r] == 2) else begin
					$display("mismatch result_valid latency rd %0d: got %h expected %h",
						r, cycles - fl_time[r], 2);
					errors++;
				end
			end
			m_val[r] = exp;
			m_pend[r] = 1'b0;
			fl_valid[r] = 1'b0;
		end
		results++;
	endtask

	always @(negedge CLK) begin
		if (rst_n) begin
			if (credit_return) begin
				credits++;
				credit_seen++;
			end
			if (result_valid)
				check_result();
		end
	end

	task automatic next_cycle();
		@(posedge CLK);
		#1;
		dispatch_valid = 1'b0;	// Strobes last one cycle
		alloc_valid = 1'b0;
		ext_wb_valid = 1'b0;
	endtask

	task automatic put_dispatch(logic_cmp_pkg::lc_op_e op, int rd, int rs1, int rs2,
			logic [63:0] imm);
		dispatch_valid = 1'b1;
		dispatch_op = op;
		dispatch_rd = rd[4:0];
		dispatch_rs1 = rs1[4:0];
		dispatch_rs2 = rs2[4:0];
		dispatch_imm = imm;
		fl_valid[rd] = 1'b1;
		fl_op[rd] = op;
		fl_rs1[rd] = rs1;
		fl_rs2[rd] = rs2;
		fl_imm[rd] = imm;
		fl_time[rd] = cycles + 1;
		m_pend[rd] = 1'b1;
		credits--;
		dispatched++;
	endtask

	task automatic issue_instr(logic_cmp_pkg::lc_op_e op, int rd, int rs1, int rs2,
			logic [63:0] imm);
		next_cycle();
		while (credits == 0)
			next_cycle();
		put_dispatch(op, rd, rs1, rs2, imm);
	endtask

	task automatic put_alloc(int rd);
		alloc_valid = 1'b1;
		alloc_rd = rd[4:0];
		m_pend[rd] = 1'b1;
	endtask

	task automatic put_ext_wb(int rd, logic [63:0] data);
		ext_wb_valid = 1'b1;
		ext_wb_rd = rd[4:0];
		ext_wb_data = data;
		m_val[rd] = data;
		m_pend[rd] = 1'b0;
	endtask

	task automatic load_reg(int rd, logic [63:0] data);
		next_cycle();
		put_ext_wb(rd, data);
	endtask

	task automatic wait_idle();
		next_cycle();
		while (!all_idle())
			next_cycle();
	endtask

	task automatic end_test(string name, int base);
		$display("%-26s %s, %0d errors", name, (errors == base) ? "passed" : "failed",
			errors - base);
	endtask

	initial begin
		int base;
		int count;
		int r;
		int rd;
		int rs1;
		int rs2;
		int start_d;
		int start_r;
		logic [15:0] rnd;
		logic [63:0] edge_val [4];

		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op = logic_cmp_pkg::OP_SLTI;
		dispatch_rd = '0;
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		dispatch_imm = '0;
		alloc_valid = 1'b0;
		alloc_rd = '0;
		ext_wb_valid = 1'b0;
		ext_wb_rd = '0;
		ext_wb_data = '0;
		for (int i = 0; i < 32; i++)
			m_val[i] = '0;
		repeat (10) @(posedge CLK);
		#1 rst_n = 1'b1;

		base = errors;
		repeat (3) begin
			next_cycle();
			@(negedge CLK);
			a_idle: assert (!credit_return && !result_valid) else begin
				$display("credit_return or result_valid high with nothing dispatched");
				errors++;
			end
		end
		// Back to back with no credit wait, each result two cycles after its dispatch
		check_latency = 1'b1;
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			put_dispatch(logic_cmp_pkg::lc_op_e'(i + 4), i + 1, i + 8, i + 12, rand_imm());
		end
		wait_idle();
		end_test("reset and first dispatch", base);

		base = errors;
		load_reg(1, rand_word());
		load_reg(2, rand_word());
		for (int i = 0; i < 10; i++) begin
			issue_instr(logic_cmp_pkg::lc_op_e'(i), 10 + i, 1, 2, rand_imm());
			wait_idle();
		end
		end_test("all opcodes", base);

		base = errors;
		edge_val[0] = 64'h8000_0000_0000_0000;
		edge_val[1] = '1;
		edge_val[2] = '0;
		edge_val[3] = 64'h8000_0000_0000_0000;	// Equal to the first
		for (int i = 0; i < 4; i++)
			load_reg(i + 1, edge_val[i]);
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				issue_instr(logic_cmp_pkg::OP_SLT, 20, i + 1, j + 1, '0);
				issue_instr(logic_cmp_pkg::OP_SLTU, 21, i + 1, j + 1, '0);
				issue_instr(logic_cmp_pkg::OP_SLTI, 22, i + 1, 0, edge_val[j]);
				issue_instr(logic_cmp_pkg::OP_SLTIU, 23, i + 1, 0, edge_val[j]);
				wait_idle();
			end
		end
		check_latency = 1'b0;
		end_test("compare edge values", base);

		base = errors;
		next_cycle();
		put_alloc(5);
		issue_instr(logic_cmp_pkg::OP_XOR, 6, 5, 1, '0);
		issue_instr(logic_cmp_pkg::OP_AND, 7, 6, 2, '0);	// Depends on the XOR
		count = results;
		repeat (10) next_cycle();
		a_blocked: assert (results == count) else begin
			$display("a result appeared while its source was still pending");
			errors++;
		end
		load_reg(5, rand_word());
		wait_idle();
		end_test("pending source", base);

		base = errors;
		next_cycle();
		put_alloc(8);
		issue_instr(logic_cmp_pkg::OP_ORI, 24, 8, 3, rand_imm());
		issue_instr(logic_cmp_pkg::OP_SLTU, 25, 8, 3, '0);
		issue_instr(logic_cmp_pkg::OP_ANDI, 26, 8, 3, rand_imm());
		issue_instr(logic_cmp_pkg::OP_SLT, 27, 8, 3, '0);
		a_no_credit: assert (credits == 0) else begin
			$display("four blocked entries left %0d credits", credits);
			errors++;
		end
		count = credit_seen;
		repeat (8) next_cycle();
		load_reg(8, rand_word());
		wait_idle();
		a_credits_back: assert (credit_seen - count == 4) else begin
			$display("mismatch credit_return pulses: got %h expected %h", credit_seen - count, 4);
			errors++;
		end
		end_test("credit exhaustion", base);

		base = errors;
		start_d = dispatched;
		start_r = results;
		while (dispatched - start_d < 200) begin
			next_cycle();
			rnd = lcg_next();
			if (ext_q.size() > 0 && rnd[1:0] == 2'd0) begin
				put_ext_wb(ext_q.pop_front(), rand_word());
			end else if (ext_q.size() < 2 && rnd[4:2] == 3'd0) begin
				r = pick_free_reg(lcg_next() % 32);
				if (r >= 0) begin
					put_alloc(r);
					ext_q.push_back(r);
				end
			end
			rd = pick_free_reg(lcg_next() % 32);
			if (credits > 0 && rnd[6:5] != 2'd0 && rd >= 0) begin
				rs1 = lcg_next() % 32;
				rs2 = lcg_next() % 32;
				if (rs1 == rd)
					rs1 = (rd + 1) % 32;
				if (rs2 == rd)
					rs2 = (rd + 2) % 32;
				put_dispatch(logic_cmp_pkg::lc_op_e'(lcg_next() % 10), rd, rs1, rs2, rand_imm());
			end
		end
		while (ext_q.size() > 0)
			load_reg(ext_q.pop_front(), rand_word());
		wait_idle();
		a_count: assert (results - start_r == dispatched - start_d) else begin
			$display("mismatch result count: got %h expected %h", results - start_r,
				dispatched - start_d);
			errors++;
		end
		end_test("random stream", base);

		$display("%0d dispatches, %0d results, %0d errors", dispatched, results, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/logic_cmp.sv
/*
 * Top of the logic and compare issue path
 */
`timescale 1ns/1ns
`default_nettype none

module logic_cmp (
	input wire CLK,
	input wire rst_n,

	input wire dispatch_valid,
	input wire logic_cmp_pkg::lc_op_e dispatch_op,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rd,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rs1,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rs2,
	input wire [logic_cmp_pkg::XLEN-1:0] dispatch_imm,
	output logic credit_return,

	input wire alloc_valid,
	input wire [logic_cmp_pkg::PREG_W-1:0] alloc_rd,

	input wire ext_wb_valid,
	input wire [logic_cmp_pkg::PREG_W-1:0] ext_wb_rd,
	input wire [logic_cmp_pkg::XLEN-1:0] ext_wb_data,

	output logic result_valid,
	output logic [logic_cmp_pkg::PREG_W-1:0] result_rd,
	output logic [logic_cmp_pkg::XLEN-1:0] result_data
);

	logic [logic_cmp_pkg::BUF_DEPTH-1:0] entry_valid;
	logic_cmp_pkg::lc_op_e [logic_cmp_pkg::BUF_DEPTH-1:0] entry_op;
	logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rd;
	logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rs1;
	logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rs2;
	logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::XLEN-1:0] entry_imm;
	logic pop;
	logic [logic_cmp_pkg::BUF_IDX_W-1:0] pop_index;

	logic [logic_cmp_pkg::PREG_NUM-1:0] wb_log;
	logic [logic_cmp_pkg::PREG_NUM-1:0][logic_cmp_pkg::XLEN-1:0] reg_read;

	logic exe_valid;
	logic_cmp_pkg::exe_fun_e exe_fun;
	logic exe_unsigned;
	logic [logic_cmp_pkg::PREG_W-1:0] exe_rd;
	logic [logic_cmp_pkg::XLEN-1:0] exe_op1;
	logic [logic_cmp_pkg::XLEN-1:0] exe_op2;

	issue_buffer i_buffer (
		.CLK(CLK), .rst_n(rst_n),
		.dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
		.dispatch_rd(dispatch_rd), .dispatch_rs1(dispatch_rs1),
		.dispatch_rs2(dispatch_rs2), .dispatch_imm(dispatch_imm),
		.pop(pop), .pop_index(pop_index),
		.entry_valid(entry_valid), .entry_op(entry_op), .entry_rd(entry_rd),
		.entry_rs1(entry_rs1), .entry_rs2(entry_rs2), .entry_imm(entry_imm),
		.credit_return(credit_return)
	);

	issue_select i_select (
		.CLK(CLK), .rst_n(rst_n),
		.entry_valid(entry_valid), .entry_op(entry_op), .entry_rd(entry_rd),
		.entry_rs1(entry_rs1), .entry_rs2(entry_rs2), .entry_imm(entry_imm),
		.wb_log(wb_log), .reg_read(reg_read),
		.pop(pop), .pop_index(pop_index),
		.exe_valid(exe_valid), .exe_fun(exe_fun), .exe_unsigned(exe_unsigned),
		.exe_rd(exe_rd), .exe_op1(exe_op1), .exe_op2(exe_op2)
	);

	logic_cmp_exec i_exec (
		.CLK(CLK), .rst_n(rst_n),
		.exe_valid(exe_valid), .exe_fun(exe_fun), .exe_unsigned(exe_unsigned),
		.exe_rd(exe_rd), .exe_op1(exe_op1), .exe_op2(exe_op2),
		.result_valid(result_valid), .result_rd(result_rd), .result_data(result_data)
	);

	reg_file i_reg_file (
		.CLK(CLK), .rst_n(rst_n),
		.dispatch_valid(dispatch_valid), .dispatch_rd(dispatch_rd),
		.alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
		.result_valid(result_valid), .result_rd(result_rd), .result_data(result_data),
		.ext_wb_valid(ext_wb_valid), .ext_wb_rd(ext_wb_rd), .ext_wb_data(ext_wb_data),
		.wb_log(wb_log), .reg_read(reg_read)
	);

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
/*
 * Physical register file with execute and external write ports,
 * plus the written-back log
 */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input wire CLK,
	input wire rst_n,

	input wire dispatch_valid,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rd,
	input wire alloc_valid,
	input wire [logic_cmp_pkg::PREG_W-1:0] alloc_rd,

	input wire result_valid,
	input wire [logic_cmp_pkg::PREG_W-1:0] result_rd,
	input wire [logic_cmp_pkg::XLEN-1:0] result_data,
	input wire ext_wb_valid,
	input wire [logic_cmp_pkg::PREG_W-1:0] ext_wb_rd,
	input wire [logic_cmp_pkg::XLEN-1:0] ext_wb_data,

	output logic [logic_cmp_pkg::PREG_NUM-1:0] wb_log,
	output logic [logic_cmp_pkg::PREG_NUM-1:0][logic_cmp_pkg::XLEN-1:0] reg_read
);

	logic [logic_cmp_pkg::PREG_NUM-1:0] log_q;
	logic [logic_cmp_pkg::PREG_NUM-1:0][logic_cmp_pkg::XLEN-1:0] regs;

	// Later statements win: execute over external write, a clear over a set
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			log_q <= '1;	// Every register starts written back
		end else begin
			if (ext_wb_valid)
				log_q[ext_wb_rd] <= 1'b1;
			if (result_valid)
				log_q[result_rd] <= 1'b1;
			if (alloc_valid)
				log_q[alloc_rd] <= 1'b0;
			if (dispatch_valid)
				log_q[dispatch_rd] <= 1'b0;
		end
	end

	// Architected zero after reset is part of the startup state
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '0;
		end else begin
			if (ext_wb_valid)
				regs[ext_wb_rd] <= ext_wb_data;
			if (result_valid)
				regs[result_rd] <= result_data;
		end
	end

	// The result register acts as the write stage of the file, so its
	// contents count as written back from the edge that loaded it
	always_comb begin
		wb_log = log_q;
		reg_read = regs;
		if (result_valid) begin
			wb_log[result_rd] = 1'b1;
			reg_read[result_rd] = result_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/logic_cmp_exec.sv
/*
 * Execute stage for set-less-than and bitwise logic, registered result
 */
`timescale 1ns/1ns
`default_nettype none

module logic_cmp_exec (
	input wire CLK,
	input wire rst_n,

	input wire exe_valid,
	input wire logic_cmp_pkg::exe_fun_e exe_fun,
	input wire exe_unsigned,
	input wire [logic_cmp_pkg::PREG_W-1:0] exe_rd,
	input wire [logic_cmp_pkg::XLEN-1:0] exe_op1,
	input wire [logic_cmp_pkg::XLEN-1:0] exe_op2,

	output logic result_valid,
	output logic [logic_cmp_pkg::PREG_W-1:0] result_rd,
	output logic [logic_cmp_pkg::XLEN-1:0] result_data
);

	logic less;
	logic [logic_cmp_pkg::XLEN-1:0] result_nxt;

	always_comb begin
		if (exe_unsigned)
			less = exe_op1 < exe_op2;
		else
			less = $signed(exe_op1) < $signed(exe_op2);

		case (exe_fun)
			logic_cmp_pkg::FUN_SLT: result_nxt = {{(logic_cmp_pkg::XLEN - 1){1'b0}}, less};
			logic_cmp_pkg::FUN_XOR: result_nxt = exe_op1 ^ exe_op2;
			logic_cmp_pkg::FUN_OR: result_nxt = exe_op1 | exe_op2;
			default: result_nxt = exe_op1 & exe_op2;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= exe_valid;
	end

	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			result_rd <= exe_rd;
			result_data <= result_nxt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/issue_select.sv
/*
 * Issue selector: source readiness, lowest ready entry pick,
 * operand muxing and the registered execute parameters
 */
`timescale 1ns/1ns
`default_nettype none

module issue_select (
	input wire CLK,
	input wire rst_n,

	input wire [logic_cmp_pkg::BUF_DEPTH-1:0] entry_valid,
	input wire logic_cmp_pkg::lc_op_e [logic_cmp_pkg::BUF_DEPTH-1:0] entry_op,
	input wire [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rd,
	input wire [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rs1,
	input wire [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rs2,
	input wire [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::XLEN-1:0] entry_imm,

	input wire [logic_cmp_pkg::PREG_NUM-1:0] wb_log,
	input wire [logic_cmp_pkg::PREG_NUM-1:0][logic_cmp_pkg::XLEN-1:0] reg_read,

	output logic pop,
	output logic [logic_cmp_pkg::BUF_IDX_W-1:0] pop_index,

	output logic exe_valid,
	output logic_cmp_pkg::exe_fun_e exe_fun,
	output logic exe_unsigned,
	output logic [logic_cmp_pkg::PREG_W-1:0] exe_rd,
	output logic [logic_cmp_pkg::XLEN-1:0] exe_op1,
	output logic [logic_cmp_pkg::XLEN-1:0] exe_op2
);

	logic [logic_cmp_pkg::BUF_DEPTH-1:0] is_imm;
	logic [logic_cmp_pkg::BUF_DEPTH-1:0] ready;
	logic_cmp_pkg::exe_fun_e fun_nxt;
	logic unsigned_nxt;
	logic [logic_cmp_pkg::XLEN-1:0] op1_nxt;
	logic [logic_cmp_pkg::XLEN-1:0] op2_nxt;

	// Immediate forms wait on rs1 only, register forms on both sources
	always_comb begin
		for (int i = 0; i < logic_cmp_pkg::BUF_DEPTH; i++) begin
			case (entry_op[i])
				logic_cmp_pkg::OP_SLTI, logic_cmp_pkg::OP_SLTIU, logic_cmp_pkg::OP_XORI,
				logic_cmp_pkg::OP_ORI, logic_cmp_pkg::OP_ANDI: is_imm[i] = 1'b1;
				default: is_imm[i] = 1'b0;
			endcase
			ready[i] = entry_valid[i] & wb_log[entry_rs1[i]]
				& (is_imm[i] | wb_log[entry_rs2[i]]);
		end
	end

	// Priority encoder, lowest index wins
	always_comb begin
		pop = 1'b0;
		pop_index = '0;
		for (int i = logic_cmp_pkg::BUF_DEPTH - 1; i >= 0; i--) begin
			if (ready[i]) begin
				pop = 1'b1;
				pop_index = i[logic_cmp_pkg::BUF_IDX_W-1:0];
			end
		end
	end

	always_comb begin
		unsigned_nxt = 1'b0;
		case (entry_op[pop_index])
			logic_cmp_pkg::OP_SLTI, logic_cmp_pkg::OP_SLT: fun_nxt = logic_cmp_pkg::FUN_SLT;
			logic_cmp_pkg::OP_SLTIU, logic_cmp_pkg::OP_SLTU: begin
				fun_nxt = logic_cmp_pkg::FUN_SLT;
				unsigned_nxt = 1'b1;
			end
			logic_cmp_pkg::OP_XORI, logic_cmp_pkg::OP_XOR: fun_nxt = logic_cmp_pkg::FUN_XOR;
			logic_cmp_pkg::OP_ORI, logic_cmp_pkg::OP_OR: fun_nxt = logic_cmp_pkg::FUN_OR;
			default: fun_nxt = logic_cmp_pkg::FUN_AND;
		endcase
		op1_nxt = reg_read[entry_rs1[pop_index]];
		op2_nxt = is_imm[pop_index] ? entry_imm[pop_index] : reg_read[entry_rs2[pop_index]];
	end

	// Execute never stalls, so every pick goes straight into the parameter register
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			exe_valid <= 1'b0;
		else
			exe_valid <= pop;
	end

	always_ff @(posedge CLK) begin
		if (pop) begin
			exe_fun <= fun_nxt;
			exe_unsigned <= unsigned_nxt;
			exe_rd <= entry_rd[pop_index];
			exe_op1 <= op1_nxt;
			exe_op2 <= op2_nxt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/issue_buffer.sv
/*
 * Issue buffer: entry storage, lowest free entry allocation, credit return
 */
`timescale 1ns/1ns
`default_nettype none

module issue_buffer (
	input wire CLK,
	input wire rst_n,

	input wire dispatch_valid,
	input wire logic_cmp_pkg::lc_op_e dispatch_op,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rd,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rs1,
	input wire [logic_cmp_pkg::PREG_W-1:0] dispatch_rs2,
	input wire [logic_cmp_pkg::XLEN-1:0] dispatch_imm,

	input wire pop,
	input wire [logic_cmp_pkg::BUF_IDX_W-1:0] pop_index,

	output logic [logic_cmp_pkg::BUF_DEPTH-1:0] entry_valid,
	output logic_cmp_pkg::lc_op_e [logic_cmp_pkg::BUF_DEPTH-1:0] entry_op,
	output logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rd,
	output logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rs1,
	output logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::PREG_W-1:0] entry_rs2,
	output logic [logic_cmp_pkg::BUF_DEPTH-1:0][logic_cmp_pkg::XLEN-1:0] entry_imm,

	output logic credit_return
);

	logic [logic_cmp_pkg::BUF_IDX_W-1:0] alloc_index;

	// Lowest free entry. The dispatcher's credits guarantee one exists
	// whenever dispatch_valid is high
	always_comb begin
		alloc_index = '0;
		for (int i = logic_cmp_pkg::BUF_DEPTH - 1; i >= 0; i--) begin
			if (!entry_valid[i])
				alloc_index = i[logic_cmp_pkg::BUF_IDX_W-1:0];
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			entry_valid <= '0;
			credit_return <= 1'b0;
		end else begin
			// A popped entry is valid and the allocated one is free, so they never collide
			if (pop)
				entry_valid[pop_index] <= 1'b0;
			if (dispatch_valid)
				entry_valid[alloc_index] <= 1'b1;
			credit_return <= pop;	// One credit back per issued entry
		end
	end

	always_ff @(posedge CLK) begin
		if (dispatch_valid) begin
			entry_op[alloc_index] <= dispatch_op;
			entry_rd[alloc_index] <= dispatch_rd;
			entry_rs1[alloc_index] <= dispatch_rs1;
			entry_rs2[alloc_index] <= dispatch_rs2;
			entry_imm[alloc_index] <= dispatch_imm;
		end
	end

endmodule

`default_nettype wire

// File: verilog/logic_cmp_pkg.sv
/*
 * Shared widths and depths of the logic and compare issue path,
 * plus the opcode and execute function enums
 */
`default_nettype none

package logic_cmp_pkg;

	localparam int XLEN = 64;	// Data width
	localparam int PREG_NUM = 32;	// Physical registers
	localparam int PREG_W = 5;
	localparam int BUF_DEPTH = 4;	// Issue buffer entries
	localparam int BUF_IDX_W = 2;

	// Opcodes handled by this path, immediate forms first within each group
	typedef enum logic [3:0] {
		OP_SLTI = 4'd0,
		OP_SLTIU = 4'd1,
		OP_SLT = 4'd2,
		OP_SLTU = 4'd3,
		OP_XORI = 4'd4,
		OP_ORI = 4'd5,
		OP_ANDI = 4'd6,
		OP_XOR = 4'd7,
		OP_OR = 4'd8,
		OP_AND = 4'd9
	} lc_op_e;

	// What the execute stage computes; signedness travels separately
	typedef enum logic [1:0] {
		FUN_SLT = 2'd0,
		FUN_XOR = 2'd1,
		FUN_OR = 2'd2,
		FUN_AND = 2'd3
	} exe_fun_e;

endpackage

`default_nettype wire
